//--- wallacePkg.sv
// Wallace tree shared constants

//////////////////////////////////////////////////
// Sizes, row counts and latency for the 16x16
// carry-save reduction tree
//////////////////////////////////////////////////

package wallacePkg;

	// Input partial products
	localparam int ppWidth = 16;
	localparam int ppCount = 16;

	// Aligned rows and the two output operands
	localparam int opWidth = 32;

	// One register per stage, so this is also the latency in cycles
	localparam int stageCount = 6;

	//////////////////////////////////////////////////
	// Rows entering each stage
	//////////////////////////////////////////////////

	// Entry s is the input count of stage s
	// Entry s+1 is what stage s hands on
	// Every 3:2 group turns three rows into two,
	// one or two rows left over pass straight through
	localparam int stageRows [0:stageCount] = '{16, 11, 8, 6, 4, 3, 2};

	// Row count after one layer of 3:2 compressors
	function automatic int reducedRows(input int rowsIn);
		int groups;
		int leftover;
		groups = rowsIn / 3;
		leftover = rowsIn - 3 * groups;
		return 2 * groups + leftover;
	endfunction

	// Number of full 3:2 groups in a layer
	function automatic int groupsOf(input int rowsIn);
		return rowsIn / 3;
	endfunction

	// Rows that fall outside the last group
	function automatic int leftoverOf(input int rowsIn);
		return rowsIn - 3 * (rowsIn / 3);
	endfunction

endpackage

//--- csaStage.sv
// Registered 3:2 compression layer

`timescale 1ns/10ps

//////////////////////////////////////////////////
// One stage of the reduction tree
//
// Input rows are split into groups of three from
// row 0. Each group gives a sum row and a carry
// row. Rows left over after the last group pass
// through unchanged. Result and valid are both
// registered, so the stage costs one cycle.
//////////////////////////////////////////////////

module csaStage #(
	parameter int stageIndex = 0
) (
	input  logic clk,
	input  logic reset,

	input  logic inValid,
	input  logic [wallacePkg::stageRows[stageIndex]-1:0][wallacePkg::opWidth-1:0] inRows,

	output logic outValid,
	output logic [wallacePkg::stageRows[stageIndex+1]-1:0][wallacePkg::opWidth-1:0] outRows
);

	localparam int rowWidth = wallacePkg::opWidth;
	localparam int inCount = wallacePkg::stageRows[stageIndex];
	localparam int outCount = wallacePkg::stageRows[stageIndex + 1];
	localparam int groupCount = wallacePkg::groupsOf(inCount);
	localparam int leftCount = wallacePkg::leftoverOf(inCount);

	// Combinational result of this layer
	logic [outCount-1:0][rowWidth-1:0] nextRows;

	//////////////////////////////////////////////////
	// Table consistency
	//////////////////////////////////////////////////

	// The row table must agree with what one layer of 3:2 groups produces
	if (wallacePkg::reducedRows(inCount) != outCount) begin : rowCountCheck
		$error("csaStage %0d: %0d rows in cannot reduce to %0d rows out",
			stageIndex, inCount, outCount);
	end

	//////////////////////////////////////////////////
	// 3:2 compressor groups
	//////////////////////////////////////////////////

	genvar k;
	generate
		for (k = 0; k < groupCount; k++) begin : group
			logic [rowWidth-1:0] rowA;
			logic [rowWidth-1:0] rowB;
			logic [rowWidth-1:0] rowC;
			logic [rowWidth-1:0] majority;

			assign rowA = inRows[3 * k];
			assign rowB = inRows[3 * k + 1];
			assign rowC = inRows[3 * k + 2];

			// Full adder per bit column
			assign majority = (rowA & rowB) | (rowA & rowC) | (rowB & rowC);

			// Sum stays in place
			assign nextRows[2 * k] = rowA ^ rowB ^ rowC;

			// Carry moves up one column, the top carry falls off (mod 2^32)
			assign nextRows[2 * k + 1] = {majority[rowWidth-2:0], 1'b0};
		end
	endgenerate

	//////////////////////////////////////////////////
	// Leftover rows
	//////////////////////////////////////////////////

	// Placed right after the last sum/carry pair
	genvar j;
	generate
		for (j = 0; j < leftCount; j++) begin : passRow
			assign nextRows[2 * groupCount + j] = inRows[3 * groupCount + j];
		end
	endgenerate

	//////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////

	// Valid flag
	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;
		end
	end

	// Data only loads on a valid sample, bubbles leave it alone
	always_ff @(posedge clk) begin
		if (inValid) begin
			outRows <= nextRows;
		end
	end

endmodule

//--- wallaceTree16x16.sv
// Pipelined 16x16 Wallace tree

`timescale 1ns/10ps

//////////////////////////////////////////////////
// Sixteen 16-bit partial products in, two 32-bit
// operands out. Row i carries weight 2^i. After
// six registered 3:2 layers, opa + opb (mod 2^32)
// equals the weighted sum of the rows.
//
// Row counts per stage: 16 11 8 6 4 3 2
// Latency is six cycles, one sample per cycle.
//////////////////////////////////////////////////

module wallaceTree16x16 (
	input  logic clk,
	input  logic reset,

	input  logic inValid,
	input  logic [wallacePkg::ppCount-1:0][wallacePkg::ppWidth-1:0] pp,

	output logic outValid,
	output logic [wallacePkg::opWidth-1:0] opa,
	output logic [wallacePkg::opWidth-1:0] opb
);

	localparam int rowWidth = wallacePkg::opWidth;
	localparam int padWidth = wallacePkg::opWidth - wallacePkg::ppWidth;

	// Valid flag in front of each stage, last entry is the output
	logic [wallacePkg::stageCount:0] stageValid;

	// Rows between stages, rowsN feeds stage N
	logic [wallacePkg::stageRows[0]-1:0][rowWidth-1:0] rows0;
	logic [wallacePkg::stageRows[1]-1:0][rowWidth-1:0] rows1;
	logic [wallacePkg::stageRows[2]-1:0][rowWidth-1:0] rows2;
	logic [wallacePkg::stageRows[3]-1:0][rowWidth-1:0] rows3;
	logic [wallacePkg::stageRows[4]-1:0][rowWidth-1:0] rows4;
	logic [wallacePkg::stageRows[5]-1:0][rowWidth-1:0] rows5;
	logic [wallacePkg::stageRows[6]-1:0][rowWidth-1:0] rows6;

	//////////////////////////////////////////////////
	// Input alignment
	//////////////////////////////////////////////////

	// Zero-extend each row and move it to its weight
	// Row 15 tops out at bit 30, so nothing is lost
	genvar i;
	generate
		for (i = 0; i < wallacePkg::ppCount; i++) begin : align
			assign rows0[i] = {{padWidth{1'b0}}, pp[i]} << i;
		end
	endgenerate

	assign stageValid[0] = inValid;

	//////////////////////////////////////////////////
	// Reduction stages
	//////////////////////////////////////////////////

	// 16 -> 11
	csaStage #(
		.stageIndex(0)
	) stage0 (
		.clk      (clk),
		.reset    (reset),
		.inValid  (stageValid[0]),
		.inRows   (rows0),
		.outValid (stageValid[1]),
		.outRows  (rows1)
	);

	// 11 -> 8
	csaStage #(
		.stageIndex(1)
	) stage1 (
		.clk      (clk),
		.reset    (reset),
		.inValid  (stageValid[1]),
		.inRows   (rows1),
		.outValid (stageValid[2]),
		.outRows  (rows2)
	);

	// 8 -> 6
	csaStage #(
		.stageIndex(2)
	) stage2 (
		.clk      (clk),
		.reset    (reset),
		.inValid  (stageValid[2]),
		.inRows   (rows2),
		.outValid (stageValid[3]),
		.outRows  (rows3)
	);

	// 6 -> 4
	csaStage #(
		.stageIndex(3)
	) stage3 (
		.clk      (clk),
		.reset    (reset),
		.inValid  (stageValid[3]),
		.inRows   (rows3),
		.outValid (stageValid[4]),
		.outRows  (rows4)
	);

	// 4 -> 3
	csaStage #(
		.stageIndex(4)
	) stage4 (
		.clk      (clk),
		.reset    (reset),
		.inValid  (stageValid[4]),
		.inRows   (rows4),
		.outValid (stageValid[5]),
		.outRows  (rows5)
	);

	// 3 -> 2, the final sum/carry pair
	csaStage #(
		.stageIndex(5)
	) stage5 (
		.clk      (clk),
		.reset    (reset),
		.inValid  (stageValid[5]),
		.inRows   (rows5),
		.outValid (stageValid[6]),
		.outRows  (rows6)
	);

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	// Carry-propagate add of opa and opb is left to the consumer
	assign opa = rows6[0];
	assign opb = rows6[1];
	assign outValid = stageValid[wallacePkg::stageCount];

endmodule

//--- wallaceTreeAssertions.sv
// Wallace tree valid timing checks

`timescale 1ns/10ps

module wallaceTreeAssertions (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic outValid,
	input logic [wallacePkg::opWidth-1:0] opa,
	input logic [wallacePkg::opWidth-1:0] opb
);

	localparam int latency = wallacePkg::stageCount;

	// Reset seen on each of the last six edges
	logic [latency-1:0] resetHist = '1;

	always @(posedge clk) begin
		resetHist <= {resetHist[latency-2:0], reset};
	end

	//////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////

	resetClearsValid: assert property (@(posedge clk) reset |=> !outValid)
		else $error("outValid high in the cycle after reset");

	// Only once no reset can have wiped a sample in flight
	validLatency: assert property (@(posedge clk)
		(resetHist == '0) |-> (outValid == $past(inValid, latency)))
		else $error("outValid does not follow inValid by %0d cycles", latency);

	knownOperands: assert property (@(posedge clk) outValid |-> !$isunknown({opa, opb}))
		else $error("opa or opb has unknown bits while outValid is high");

endmodule

bind wallaceTree16x16 wallaceTreeAssertions assertions (.*);

//--- wallaceTreeTb.sv
// Wallace tree testbench

`timescale 1ns/10ps

module wallaceTreeTb;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 16;
	localparam int tableLen = 64;
	localparam int midResetAt = 44;
	localparam int midResetCycles = 2;
	localparam int latency = wallacePkg::stageCount;
	localparam int timeoutNs = 2 * (resetCycles + tableLen + latency) * clkPeriod;
	localparam int padWidth = wallacePkg::opWidth - wallacePkg::ppWidth;

	logic clk;
	logic reset;
	logic inValid;
	logic [wallacePkg::ppCount-1:0][wallacePkg::ppWidth-1:0] pp;
	logic outValid;
	logic [wallacePkg::opWidth-1:0] opa;
	logic [wallacePkg::opWidth-1:0] opb;

	// Stimulus table
	logic tabValid [tableLen];
	logic [wallacePkg::ppCount-1:0][wallacePkg::ppWidth-1:0] tabRows [tableLen];
	logic [wallacePkg::opWidth-1:0] tabSum [tableLen];

	// Samples in flight with the oldest first
	int sentQ [$];
	logic [wallacePkg::opWidth-1:0] expectQ [$];

	int cycle = 0;
	int seed = 80327;
	int checkedCount = 0;

	wallaceTree16x16 uut (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.pp       (pp),
		.outValid (outValid),
		.opa      (opa),
		.opb      (opb)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clkPeriod / 2);
			clk = ~clk;
		end
	end

	// Rising edges since time zero
	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	//////////////////////////////////////////////////
	// Reference arithmetic and table
	//////////////////////////////////////////////////

	// Row i weighted by 2^i modulo 2^32
	function automatic logic [wallacePkg::opWidth-1:0] weightedSum(
		input logic [wallacePkg::ppCount-1:0][wallacePkg::ppWidth-1:0] rows
	);
		logic [wallacePkg::opWidth-1:0] total;
		total = '0;
		for (int i = 0; i < wallacePkg::ppCount; i++) begin
			total = total + ({{padWidth{1'b0}}, rows[i]} << i);
		end
		return total;
	endfunction

	// Row i is a when bit i of b is set
	function automatic logic [wallacePkg::ppCount-1:0][wallacePkg::ppWidth-1:0] productRows(
		input logic [wallacePkg::ppWidth-1:0] a,
		input logic [wallacePkg::ppWidth-1:0] b
	);
		logic [wallacePkg::ppCount-1:0][wallacePkg::ppWidth-1:0] rows;
		for (int i = 0; i < wallacePkg::ppCount; i++) begin
			rows[i] = b[i] ? a : '0;
		end
		return rows;
	endfunction

	function automatic logic [wallacePkg::ppWidth-1:0] randomRow();
		int r;
		r = $random(seed);
		return r[wallacePkg::ppWidth-1:0];
	endfunction

	task automatic fillTable();
		for (int e = 0; e < tableLen; e++) begin
			tabValid[e] = 1'b1;
			for (int r = 0; r < wallacePkg::ppCount; r++) begin
				tabRows[e][r] = randomRow();
			end
		end
		tabRows[0] = '0;
		tabRows[1] = '1;
		tabRows[2] = productRows(16'hFFFF, 16'hFFFF);
		tabRows[3] = productRows(16'hBEEF, 16'h1234);
		// One row of ones per entry in entries 4 to 19
		for (int i = 0; i < wallacePkg::ppCount; i++) begin
			tabRows[4 + i] = '0;
			tabRows[4 + i][i] = 16'hFFFF;
		end
		// Bubbles
		tabValid[20] = 1'b0;
		tabValid[21] = 1'b0;
		tabValid[33] = 1'b0;
		tabValid[50] = 1'b0;
		tabValid[63] = 1'b0;
		for (int e = 0; e < tableLen; e++) begin
			tabSum[e] = weightedSum(tabRows[e]);
		end
	endtask

	// A sample sent at least latency cycles before the mid-stream reset
	// leaves the pipe before it, later ones in flight are lost
	function automatic int expectedResults();
		int count;
		count = 0;
		for (int e = 0; e < tableLen; e++) begin
			if (tabValid[e] && (e + latency <= midResetAt || e >= midResetAt)) begin
				count++;
			end
		end
		return count;
	endfunction

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic checkValue(
		input string name,
		input logic [31:0] actual,
		input logic [31:0] expected
	);
		if (actual !== expected) begin
			$display("[ERROR] %0d ns %s: got 0x%08h, expected 0x%08h",
				$time, name, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stopWithError(input string msg);
		$display("Error at %0d ns: %s", $time, msg);
		$display("TESTS FAILED");
		$fatal(1, "%s", msg);
	endtask

	// Sampled at the falling edge between register updates
	task automatic checkOutputs();
		if (outValid === 1'b1) begin
			if (expectQ.size() == 0) begin
				stopWithError("outValid went high with no valid sample in flight");
			end else begin
				checkValue("output latency", cycle - sentQ[0], latency);
				checkValue("opa + opb", opa + opb, expectQ[0]);
				sentQ.delete(0);
				expectQ.delete(0);
				checkedCount++;
			end
		end else if (outValid !== 1'b0) begin
			stopWithError("outValid is unknown");
		end else if (sentQ.size() != 0 && cycle - sentQ[0] >= latency) begin
			checkValue("outValid", {31'b0, outValid}, 32'd1);
		end
	endtask

	initial begin
		forever begin
			@(negedge clk);
			checkOutputs();
		end
	end

	initial begin
		#(timeoutNs);
		$display("Watchdog: the run did not finish within %0d ns", timeoutNs);
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic applyEntry(input int e);
		inValid = tabValid[e];
		pp = tabRows[e];
		if (tabValid[e]) begin
			sentQ.push_back(cycle);
			expectQ.push_back(tabSum[e]);
		end
	endtask

	// Samples still inside the stages are lost
	task automatic pulseReset();
		reset = 1'b1;
		inValid = 1'b0;
		@(posedge clk);
		#1;
		sentQ.delete();
		expectQ.delete();
		repeat (midResetCycles - 1) begin
			@(posedge clk);
			#1;
		end
		reset = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		inValid = 1'b0;
		pp = '0;
		fillTable();
		checkValue("sum for 16'hFFFF squared", tabSum[2], 32'hFFFE0001);
		checkValue("sum for 16'hBEEF x 16'h1234", tabSum[3],
			{16'h0, 16'hBEEF} * {16'h0, 16'h1234});

		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int e = 0; e < tableLen; e++) begin
			if (e == midResetAt) begin
				pulseReset();
			end
			applyEntry(e);
			@(posedge clk);
			#1;
		end
		inValid = 1'b0;

		// Drain and watch for stale results
		while (expectQ.size() != 0) begin
			@(posedge clk);
		end
		repeat (latency + 2) @(posedge clk);

		if (checkedCount != expectedResults()) begin
			stopWithError($sformatf("%0d results came out where the table gives %0d",
				checkedCount, expectedResults()));
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

//--- vlog.f
wallacePkg.sv
csaStage.sv
wallaceTree16x16.sv
wallaceTreeAssertions.sv
wallaceTreeTb.sv

//--- Makefile
# Verilator build and run for the Wallace tree testbench

TOP ?= wallaceTreeTb
VERILATOR ?= verilator
FLAGS ?= --assert -j 0
FILELIST ?= vlog.f
OBJDIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator from $(FILELIST) and run $(TOP)"
	@echo "  clean  remove $(OBJDIR)"
	@echo "  help   show this list"
	@echo "Variables: TOP VERILATOR FLAGS FILELIST OBJDIR"

test:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) \
		--Mdir $(OBJDIR) -f $(FILELIST) -o V$(TOP)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
